/* verilog.f */
src/event_pkg.sv
src/link_admit.sv
src/link_monitor.sv
src/start_event_select.sv
src/event_regs.sv
src/event_top.sv
sim/event_checker.sv
sim/tb_event_top.sv

/* Makefile */
TOP = tb_event_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* sim/tb_event_top.sv */
`timescale 1ns/1ps

module tb_event_top;

    localparam int NUM_ROWS = 30;

    typedef enum logic [1:0] {
        K_WRITE,
        K_READ,
        K_BURST,
        K_OPEN
    } row_kind_e;

    typedef struct packed {
        row_kind_e   kind;
        logic [3:0]  links;    // enabled links, byte lanes on a write
        logic [3:0]  len;
        logic [3:0]  adr;
        logic [31:0] wdata;
        logic [31:0] exp_val;  // read value, or number of start pulses for a burst
    } row_t;

    logic                                             aclk;
    logic                                             arst_n_i;
    logic                                             event_open_i;
    event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] link_i;
    event_pkg::reg_req_t                              reg_req_i;
    logic                                             reg_ack_o;
    logic [31:0]                                      reg_rdata_o;
    logic                                             start_event_o;
    int                                               row_num;
    row_t                                             row_cur;
    logic                                             row_done;
    int                                               checks;
    int                                               errors;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    row_t rows [NUM_ROWS] = '{
        // reset values and the mirrored map
        '{K_READ,  4'b0000, 4'd0, 4'd0,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd4,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd5,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd6,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd7,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd12, 32'h0,   32'h0},
        // counting with the event open
        '{K_OPEN,  4'b0000, 4'd0, 4'd0,  32'h1,   32'h0},
        '{K_BURST, 4'b1111, 4'd5, 4'd0,  32'h0,   32'h1},
        '{K_BURST, 4'b0101, 4'd3, 4'd0,  32'h0,   32'h1},
        '{K_READ,  4'b0000, 4'd0, 4'd4,  32'h0,   32'h8},
        '{K_READ,  4'b0000, 4'd0, 4'd12, 32'h0,   32'h8},
        '{K_READ,  4'b0000, 4'd0, 4'd5,  32'h0,   32'h5},
        // closed event drops every beat
        '{K_OPEN,  4'b0000, 4'd0, 4'd0,  32'h0,   32'h0},
        '{K_BURST, 4'b1111, 4'd4, 4'd0,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd6,  32'h0,   32'h8},
        // reset bit only through byte lane 0
        '{K_WRITE, 4'b0001, 4'd0, 4'd0,  32'h1,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd4,  32'h0,   32'h0},
        '{K_WRITE, 4'b1110, 4'd0, 4'd0,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd0,  32'h0,   32'h1},
        '{K_WRITE, 4'b0001, 4'd0, 4'd0,  32'h0,   32'h0},
        '{K_OPEN,  4'b0000, 4'd0, 4'd0,  32'h1,   32'h0},
        // start pulse priority with mask 0000
        '{K_BURST, 4'b0011, 4'd2, 4'd0,  32'h0,   32'h1},
        '{K_BURST, 4'b0100, 4'd1, 4'd0,  32'h0,   32'h0},
        // mask 0011, then all links masked
        '{K_WRITE, 4'b0010, 4'd0, 4'd0,  32'h300, 32'h0},
        '{K_BURST, 4'b0100, 4'd2, 4'd0,  32'h0,   32'h1},
        '{K_BURST, 4'b0001, 4'd2, 4'd0,  32'h0,   32'h0},
        '{K_WRITE, 4'b0010, 4'd0, 4'd0,  32'hf00, 32'h0},
        '{K_BURST, 4'b1111, 4'd3, 4'd0,  32'h0,   32'h0},
        '{K_READ,  4'b0000, 4'd0, 4'd8,  32'h0,   32'hf00},
        '{K_READ,  4'b0000, 4'd0, 4'd4,  32'h0,   32'h7}
    };

    // worst case length of one row including the idle gap and the row end
    function automatic int row_cycles(input row_t r);
        if (r.kind == K_BURST) begin
            return int'(r.len) + 10;
        end
        return 10;
    endfunction

    task automatic apply_row(input row_t r);
        case (r.kind)
            K_WRITE, K_READ: begin
                reg_req_i.cyc <= 1'b1;
                reg_req_i.stb <= 1'b1;
                reg_req_i.we  <= (r.kind == K_WRITE);
                reg_req_i.sel <= r.links;
                reg_req_i.adr <= r.adr;
                reg_req_i.dat <= r.wdata;
                do begin
                    @(posedge aclk);
                end while (!reg_ack_o);
                reg_req_i <= '0;
            end
            K_BURST: begin
                for (int b = 0; b < int'(r.len); b++) begin
                    for (int l = 0; l < event_pkg::NUM_LINKS; l++) begin
                        link_i[l].data  <= $urandom();
                        link_i[l].valid <= r.links[l];
                        link_i[l].last  <= r.links[l] && (b == int'(r.len) - 1);
                    end
                    @(posedge aclk);
                end
                link_i <= '0;
                // start pulse lands 2 cycles after the last beat
                repeat (3) @(posedge aclk);
            end
            default: begin
                event_open_i <= r.wdata[0];
                repeat (3) @(posedge aclk);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // clock, reset, watchdog and row loop
    ////////////////////////////////////////////////////////////

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin : watchdog
        int longest;
        longest = 0;
        foreach (rows[i]) begin
            if (row_cycles(rows[i]) > longest) begin
                longest = row_cycles(rows[i]);
            end
        end
        repeat (NUM_ROWS * longest * 2) @(posedge aclk);
        $display("timeout: run did not finish within %0d cycles", NUM_ROWS * longest * 2);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int gap;
        arst_n_i     <= 1'b0;
        event_open_i <= 1'b0;
        link_i       <= '0;
        reg_req_i    <= '0;
        row_num      <= 0;
        row_cur      <= '0;
        row_done     <= 1'b0;
        void'($urandom(32'h3d9e_32de));
        repeat (2) @(posedge aclk);
        arst_n_i <= 1'b1;
        foreach (rows[i]) begin
            gap = $urandom() % 4;
            repeat (gap) @(posedge aclk);
            @(posedge aclk);
            row_num <= i;
            row_cur <= rows[i];
            apply_row(rows[i]);
            @(posedge aclk);
            row_done <= 1'b1;
            @(posedge aclk);
            row_done <= 1'b0;
        end
        // checker counts are settled away from the rising edge
        @(negedge aclk);
        $display("done: %0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    event_top i_event_top (.*);

    event_checker i_event_checker (
        .aclk           (aclk),
        .arst_n_i       (arst_n_i),
        .event_open_i   (event_open_i),
        .link_i         (link_i),
        .reg_req_i      (reg_req_i),
        .reg_ack_i      (reg_ack_o),
        .reg_rdata_i    (reg_rdata_o),
        .start_event_i  (start_event_o),
        .row_num_i      (row_num),
        .row_is_read_i  (row_cur.kind == K_READ),
        .row_is_burst_i (row_cur.kind == K_BURST),
        .row_exp_i      (row_cur.exp_val),
        .row_done_i     (row_done),
        .checks_o       (checks),
        .errors_o       (errors)
    );

endmodule

/* sim/event_checker.sv */
`timescale 1ns/1ps

module event_checker (
    input  logic                                             aclk,
    input  logic                                             arst_n_i,
    input  logic                                             event_open_i,
    input  event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] link_i,
    input  event_pkg::reg_req_t                              reg_req_i,
    input  logic                                             reg_ack_i,
    input  logic [31:0]                                      reg_rdata_i,
    input  logic                                             start_event_i,
    input  int                                               row_num_i,
    input  logic                                             row_is_read_i,
    input  logic                                             row_is_burst_i,
    input  logic [31:0]                                      row_exp_i,
    input  logic                                             row_done_i,
    output int                                               checks_o,
    output int                                               errors_o
);

    logic [1:0]                      m_open;
    logic [event_pkg::CNT_W-1:0]     m_cnt [event_pkg::NUM_LINKS];
    logic [event_pkg::NUM_LINKS-1:0] m_last;
    logic [event_pkg::NUM_LINKS-1:0] m_mask;
    logic                            m_reset;
    logic                            m_start;
    logic                            m_ack_q;
    logic                            m_ack;
    logic                            m_req;
    logic [31:0]                     m_rdata;
    int                              n_checks = 0;
    int                              n_errors = 0;
    int                              row_pulses = 0;
    int                              row_base = 0;

    assign m_req    = reg_req_i.cyc && reg_req_i.stb;
    assign m_ack    = m_ack_q && reg_req_i.cyc;
    assign checks_o = n_checks;
    assign errors_o = n_errors;

    // lowest unmasked link decides, nothing if all are masked
    function automatic logic chosen_last(input logic [event_pkg::NUM_LINKS-1:0] last,
                                         input logic [event_pkg::NUM_LINKS-1:0] mask);
        for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
            if (!mask[i]) begin
                return last[i];
            end
        end
        return 1'b0;
    endfunction

    // words 0..3 global, 4..7 counters, top address bit ignored
    function automatic logic [31:0] expected_word(input logic [3:0] adr);
        logic [31:0] w;
        w = '0;
        if (adr[2]) begin
            w = m_cnt[adr[1:0]];
        end else begin
            w[event_pkg::GLB_RESET_BIT] = m_reset;
            w[event_pkg::GLB_MASK_LSB +: event_pkg::NUM_LINKS] = m_mask;
        end
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            n_errors++;
            $display("CHECK FAILED t=%0t %s expected %0h actual %0h",
                     $time, name, exp_v, act_v);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    always @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_open  <= 2'b00;
            m_last  <= '0;
            m_mask  <= '0;
            m_reset <= 1'b0;
            m_start <= 1'b0;
            m_ack_q <= 1'b0;
            m_rdata <= '0;
            for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
                m_cnt[i] <= '0;
            end
        end else begin
            m_open <= {m_open[0], event_open_i};
            for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
                if (m_reset) begin
                    m_cnt[i] <= '0;
                end else if (link_i[i].valid && m_open[1]) begin
                    m_cnt[i] <= m_cnt[i] + 1;
                end
                m_last[i] <= link_i[i].valid && m_open[1] && link_i[i].last;
            end
            m_start <= chosen_last(m_last, m_mask);
            m_ack_q <= m_req;
            if (m_req && !reg_req_i.we && !m_ack_q) begin
                m_rdata <= expected_word(reg_req_i.adr);
            end
            if (m_req && reg_req_i.we && m_ack) begin
                if (reg_req_i.sel[0]) begin
                    m_reset <= reg_req_i.dat[event_pkg::GLB_RESET_BIT];
                end
                if (reg_req_i.sel[1]) begin
                    m_mask <= reg_req_i.dat[event_pkg::GLB_MASK_LSB +: event_pkg::NUM_LINKS];
                end
            end
        end
    end

    // compare against the model every cycle, report once per row
    always @(posedge aclk) begin
        if (arst_n_i) begin
            compare("reg_ack_o", 32'(m_ack), 32'(reg_ack_i));
            compare("start_event_o", 32'(m_start), 32'(start_event_i));
            if (reg_ack_i && !reg_req_i.we) begin
                compare("reg_rdata_o", m_rdata, reg_rdata_i);
                if (row_is_read_i) begin
                    compare("reg_rdata_o", row_exp_i, reg_rdata_i);
                end
            end
            if (start_event_i) begin
                row_pulses++;
            end
            if (row_done_i) begin
                if (row_is_burst_i) begin
                    compare("start_event_o pulse count", row_exp_i, 32'(row_pulses));
                end
                $display("row %0d %s", row_num_i, (n_errors == row_base) ? "ok" : "failed");
                row_pulses = 0;
                row_base   = n_errors;
            end
        end
    end

endmodule

/* src/event_top.sv */
`timescale 1ns/1ps

module event_top (
    input  logic                                           aclk,
    input  logic                                           arst_n_i,
    input  logic                                           event_open_i,
    input  event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] link_i,
    input  event_pkg::reg_req_t                            reg_req_i,
    output logic                                           reg_ack_o,
    output logic [31:0]                                    reg_rdata_o,
    output logic                                           start_event_o
);

    event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0]       gated;
    logic [event_pkg::NUM_LINKS-1:0][event_pkg::CNT_W-1:0] counts;
    logic [event_pkg::NUM_LINKS-1:0]                        last_seen;
    logic [event_pkg::NUM_LINKS-1:0]                        mask;
    logic                                                   event_reset;

    ////////////////////////////////////////////////////////////
    // link front end
    ////////////////////////////////////////////////////////////

    link_admit i_link_admit (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .event_open_i (event_open_i),
        .link_i       (link_i),
        .gated_o      (gated)
    );

    // one monitor per link
    for (genvar i = 0; i < event_pkg::NUM_LINKS; i++) begin : g_mon
        link_monitor i_link_monitor (
            .aclk        (aclk),
            .arst_n_i    (arst_n_i),
            .beat_i      (gated[i]),
            .clear_i     (event_reset),
            .count_o     (counts[i]),
            .last_seen_o (last_seen[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // start event and registers
    ////////////////////////////////////////////////////////////

    start_event_select i_start_event_select (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .last_seen_i   (last_seen),
        .mask_i        (mask),
        .start_event_o (start_event_o)
    );

    event_regs i_event_regs (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .req_i         (reg_req_i),
        .counts_i      (counts),
        .ack_o         (reg_ack_o),
        .rdata_o       (reg_rdata_o),
        .event_reset_o (event_reset),
        .mask_o        (mask)
    );

endmodule

/* src/event_regs.sv */
`timescale 1ns/1ps

module event_regs (
    input  logic                                              aclk,
    input  logic                                              arst_n_i,
    input  event_pkg::reg_req_t                               req_i,
    input  logic [event_pkg::NUM_LINKS-1:0][event_pkg::CNT_W-1:0] counts_i,
    output logic                                              ack_o,
    output logic [31:0]                                       rdata_o,
    output logic                                              event_reset_o,
    output logic [event_pkg::NUM_LINKS-1:0]                   mask_o
);

    logic                           ack_q;
    logic                           req_active;
    logic                           wr_strobe;
    logic                           event_reset_q;
    logic [event_pkg::NUM_LINKS-1:0] mask_q;
    logic [31:0]                    rdata_q;
    logic [31:0]                    glb_word;
    logic [31:0]                    rd_word;
    event_pkg::reg_word_e           word;

    assign req_active = req_i.cyc && req_i.stb;

    // ack follows the request by one cycle and drops with cyc
    assign ack_o = ack_q && req_i.cyc;

    // writes land while the ack is up
    assign wr_strobe = req_active && req_i.we && ack_o;

    ////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        glb_word = '0;
        glb_word[event_pkg::GLB_RESET_BIT] = event_reset_q;
        glb_word[event_pkg::GLB_MASK_LSB +: event_pkg::NUM_LINKS] = mask_q;
    end

    // top address bit dropped here so the upper half mirrors the lower half
    assign word = event_pkg::reg_word_e'(req_i.adr[$clog2(event_pkg::REG_WORDS)-1:0]);

    always_comb begin
        case (word)
            event_pkg::REG_GLOBAL0,
            event_pkg::REG_GLOBAL1,
            event_pkg::REG_GLOBAL2,
            event_pkg::REG_GLOBAL3: rd_word = glb_word;
            event_pkg::REG_COUNT0:  rd_word = counts_i[0];
            event_pkg::REG_COUNT1:  rd_word = counts_i[1];
            event_pkg::REG_COUNT2:  rd_word = counts_i[2];
            event_pkg::REG_COUNT3:  rd_word = counts_i[3];
            default:                rd_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // bus state and control bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q         <= 1'b0;
            rdata_q       <= '0;
            event_reset_q <= 1'b0;
            mask_q        <= '0;
        end else begin
            ack_q <= req_active;
            // capture read data so it is valid alongside the ack
            if (req_active && !req_i.we && !ack_q) begin
                rdata_q <= rd_word;
            end
            // byte lanes pick the field and the address is ignored
            if (wr_strobe && req_i.sel[0]) begin
                event_reset_q <= req_i.dat[event_pkg::GLB_RESET_BIT];
            end
            if (wr_strobe && req_i.sel[1]) begin
                mask_q <= req_i.dat[event_pkg::GLB_MASK_LSB +: event_pkg::NUM_LINKS];
            end
        end
    end

    assign rdata_o       = rdata_q;
    assign event_reset_o = event_reset_q;
    assign mask_o        = mask_q;

endmodule

/* src/start_event_select.sv */
`timescale 1ns/1ps

module start_event_select (
    input  logic                            aclk,
    input  logic                            arst_n_i,
    input  logic [event_pkg::NUM_LINKS-1:0] last_seen_i,
    input  logic [event_pkg::NUM_LINKS-1:0] mask_i,
    output logic                            start_event_o
);

    logic pick;
    logic start_q;

    // walk from the top down so the lowest unmasked link wins;
    // flags from every other link are ignored
    always_comb begin
        pick = 1'b0;
        for (int i = event_pkg::NUM_LINKS - 1; i >= 0; i--) begin
            if (!mask_i[i]) begin
                pick = last_seen_i[i];
            end
        end
    end

    // all links masked leaves pick at zero, so no pulse
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= pick;
        end
    end

    assign start_event_o = start_q;

endmodule

/* src/link_monitor.sv */
`timescale 1ns/1ps

module link_monitor (
    input  logic                        aclk,
    input  logic                        arst_n_i,
    input  event_pkg::link_beat_t       beat_i,
    input  logic                        clear_i,
    output logic [event_pkg::CNT_W-1:0] count_o,
    output logic                        last_seen_o
);

    logic [event_pkg::CNT_W-1:0] count_q;
    logic                        last_seen_q;
    logic                        accept;

    // no back-pressure, so a valid beat is an accepted beat
    assign accept = beat_i.valid;

    ////////////////////////////////////////////////////////////
    // dword counter that wraps on overflow
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (accept) begin
            count_q <= count_q + 1'b1;
        end
    end

    // one-cycle flag per accepted last beat
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_seen_q <= 1'b0;
        end else begin
            last_seen_q <= accept && beat_i.last;
        end
    end

    assign count_o     = count_q;
    assign last_seen_o = last_seen_q;

endmodule

/* src/link_admit.sv */
`timescale 1ns/1ps

module link_admit (
    input  logic                                           aclk,
    input  logic                                           arst_n_i,
    input  logic                                           event_open_i,
    input  event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] link_i,
    output event_pkg::link_beat_t [event_pkg::NUM_LINKS-1:0] gated_o
);

    // two-stage synchronizer for the event-open level
    logic [1:0] open_sync;
    logic       event_open;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            open_sync <= 2'b00;
        end else begin
            open_sync <= {open_sync[0], event_open_i};
        end
    end

    assign event_open = open_sync[1];

    // beats arriving while closed are dropped by killing valid
    // while data and last pass straight through
    always_comb begin
        for (int i = 0; i < event_pkg::NUM_LINKS; i++) begin
            gated_o[i].data  = link_i[i].data;
            gated_o[i].last  = link_i[i].last;
            gated_o[i].valid = link_i[i].valid && event_open;
        end
    end

endmodule

/* src/event_pkg.sv */
package event_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // link streams feeding the event builder
    localparam int NUM_LINKS = 4;
    localparam int LINK_DW   = 32;

    // per-link dword counter width
    localparam int CNT_W     = 32;

    // decoded register words; the bus address carries one more bit,
    // which is ignored so the map repeats in the upper half
    localparam int REG_WORDS = 8;

    // global word bit positions
    localparam int GLB_RESET_BIT = 0;
    localparam int GLB_MASK_LSB  = 8;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // one beat on a link stream
    typedef struct packed {
        logic [LINK_DW-1:0] data;
        logic               valid;
        logic               last;
    } link_beat_t;

    // one register bus request
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [3:0]                 sel;
        logic [$clog2(REG_WORDS):0] adr;
        logic [31:0]                dat;
    } reg_req_t;

    // decoded word within the lower half of the map
    typedef enum logic [$clog2(REG_WORDS)-1:0] {
        REG_GLOBAL0,
        REG_GLOBAL1,
        REG_GLOBAL2,
        REG_GLOBAL3,
        REG_COUNT0,
        REG_COUNT1,
        REG_COUNT2,
        REG_COUNT3
    } reg_word_e;

endpackage
